// ==== rtl/bridge_cfg_pkg.sv ====
package bridge_cfg_pkg;

  // **************************************************************************
  // Word and message widths
  // **************************************************************************

  // One word on the host streams
  localparam int host_word_w = 32;

  // One message from the application, split into two host words
  localparam int fpga_msg_w = 64;

  // **************************************************************************
  // FIFO depths
  // **************************************************************************

  // Host-to-FPGA queue and the loopback queue share this depth
  localparam int pc_fifo_depth = 16;

  // FPGA-to-host queue, counted in whole 64-bit messages
  localparam int fpga_fifo_depth = 8;

  // **************************************************************************
  // Payload types
  // **************************************************************************

  typedef logic [host_word_w-1:0] host_word_t;

  // Low word goes to the host first
  typedef logic [fpga_msg_w-1:0] fpga_msg_t;

  // All ones at the head of the host queue asks to close the read stream
  localparam host_word_t eof_marker = '1;

endpackage

// ==== rtl/host_stream_pkg.sv ====
package host_stream_pkg;

  // **************************************************************************
  // Read stream channels (FPGA to host)
  // **************************************************************************

  // Host side request on a read stream
  typedef struct packed {
    logic rden;
    logic open;
  } host_rd_req_t;

  // Data is valid whenever empty is low
  typedef struct packed {
    bridge_cfg_pkg::host_word_t data;
    logic                       empty;
    logic                       eof;
  } host_rd_rsp_t;

  // **************************************************************************
  // Write stream channel (host to FPGA)
  // **************************************************************************

  // A write is only stored while the queue reports not full
  typedef struct packed {
    logic                       wren;
    bridge_cfg_pkg::host_word_t data;
    logic                       open;
  } host_wr_req_t;

endpackage

// ==== rtl/msg_fifo.sv ====
module msg_fifo #(
  parameter type item_t = logic [31:0],
  parameter int  depth  = 16
) (
  input  logic  bus_clk,
  input  logic  arst_n,
  input  logic  push,
  input  item_t item_in,
  input  logic  pop,
  output item_t item_out,
  output logic  empty,
  output logic  full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  item_t            mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Push when full and pop when empty are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // **************************************************************************
  // Storage
  // **************************************************************************

  always_ff @(posedge bus_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= item_in;
    end
  end

  // Show-ahead head entry
  assign item_out = mem[rd_ptr];

  // **************************************************************************
  // Pointers and occupancy
  // **************************************************************************

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

endmodule

// ==== rtl/host_rd_channel.sv ====
module host_rd_channel (
  input  logic                          bus_clk,
  input  logic                          arst_n,
  input  bridge_cfg_pkg::fpga_msg_t     fpga_msg,
  input  logic                          fpga_msg_valid,
  output logic                          fpga_msg_full,
  input  host_stream_pkg::host_rd_req_t rd_req,
  output host_stream_pkg::host_rd_rsp_t rd_rsp,
  input  bridge_cfg_pkg::host_word_t    pc_head,
  input  logic                          pc_pending,
  input  logic                          app_done
);

  import bridge_cfg_pkg::*;

  fpga_msg_t head_msg;
  logic      msg_push;
  logic      msg_pop;
  logic      msg_empty;
  logic      msg_full;
  logic      take_word;
  logic      hi_half;
  logic      eof_request;

  // **************************************************************************
  // Message queue
  // **************************************************************************

  // Messages offered while the host stream is closed are dropped here
  assign msg_push = fpga_msg_valid && rd_req.open;

  // Closed stream never holds the application back
  assign fpga_msg_full = msg_full && rd_req.open;

  msg_fifo #(
    .item_t (fpga_msg_t),
    .depth  (fpga_fifo_depth)
  ) u_msg_fifo (
    .bus_clk  (bus_clk),
    .arst_n   (arst_n),
    .push     (msg_push),
    .item_in  (fpga_msg),
    .pop      (msg_pop),
    .item_out (head_msg),
    .empty    (msg_empty),
    .full     (msg_full)
  );

  // **************************************************************************
  // 64-to-32 splitting
  // **************************************************************************

  // A host read only counts when a word is there
  assign take_word = rd_req.rden && !msg_empty;

  // Entry leaves on the read of its high half
  assign msg_pop = take_word && hi_half;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      hi_half <= 1'b0;
    end else if (take_word) begin
      hi_half <= !hi_half;
    end
  end

  // **************************************************************************
  // Host response
  // **************************************************************************

  // Host asked to end with an all-ones word and nothing is left to read
  assign eof_request = pc_pending && (pc_head == eof_marker) && msg_empty;

  always_comb begin
    if (hi_half) begin
      rd_rsp.data = head_msg[fpga_msg_w-1 -: host_word_w];
    end else begin
      rd_rsp.data = head_msg[host_word_w-1:0];
    end
    rd_rsp.empty = msg_empty;
    rd_rsp.eof   = eof_request || app_done;
  end

endmodule

// ==== rtl/host_loop_channel.sv ====
module host_loop_channel (
  input  logic                          bus_clk,
  input  logic                          arst_n,
  input  bridge_cfg_pkg::host_word_t    echo_word,
  input  logic                          echo_push,
  input  logic                          wr_open,
  input  host_stream_pkg::host_rd_req_t loop_req,
  output host_stream_pkg::host_rd_rsp_t loop_rsp
);

  import bridge_cfg_pkg::*;

  host_word_t loop_head;
  logic       loop_empty;

  // Echo is lost when this queue is full, the ack itself still goes through
  msg_fifo #(
    .item_t (host_word_t),
    .depth  (pc_fifo_depth)
  ) u_loop_fifo (
    .bus_clk  (bus_clk),
    .arst_n   (arst_n),
    .push     (echo_push),
    .item_in  (echo_word),
    .pop      (loop_req.rden),
    .item_out (loop_head),
    .empty    (loop_empty),
    .full     ()
  );

  // Stream ends once the host stopped writing and every echo was read
  always_comb begin
    loop_rsp.data  = loop_head;
    loop_rsp.empty = loop_empty;
    loop_rsp.eof   = !wr_open && loop_empty;
  end

endmodule

// ==== rtl/host_bridge_top.sv ====
module host_bridge_top (
  input  logic                          bus_clk,
  input  logic                          arst_n,
  // Host streams
  input  host_stream_pkg::host_wr_req_t wr_req,
  output logic                          wr_full,
  input  host_stream_pkg::host_rd_req_t rd_req,
  output host_stream_pkg::host_rd_rsp_t rd_rsp,
  input  host_stream_pkg::host_rd_req_t loop_req,
  output host_stream_pkg::host_rd_rsp_t loop_rsp,
  // Application side
  output bridge_cfg_pkg::host_word_t    pc_msg,
  output logic                          pc_msg_pending,
  input  logic                          pc_msg_ack,
  input  bridge_cfg_pkg::fpga_msg_t     fpga_msg,
  input  logic                          fpga_msg_valid,
  output logic                          fpga_msg_full,
  input  logic                          app_done,
  output logic [3:0]                    status_led
);

  import bridge_cfg_pkg::*;

  logic pc_empty;
  logic pc_take;

  // **************************************************************************
  // Host-to-FPGA queue
  // **************************************************************************

  msg_fifo #(
    .item_t (host_word_t),
    .depth  (pc_fifo_depth)
  ) u_pc_fifo (
    .bus_clk  (bus_clk),
    .arst_n   (arst_n),
    .push     (wr_req.wren),
    .item_in  (wr_req.data),
    .pop      (pc_msg_ack),
    .item_out (pc_msg),
    .empty    (pc_empty),
    .full     (wr_full)
  );

  assign pc_msg_pending = !pc_empty;

  // Ack without a pending word echoes nothing
  assign pc_take = pc_msg_ack && pc_msg_pending;

  // **************************************************************************
  // FPGA-to-host and loopback streams
  // **************************************************************************

  host_rd_channel u_rd_channel (
    .bus_clk        (bus_clk),
    .arst_n         (arst_n),
    .fpga_msg       (fpga_msg),
    .fpga_msg_valid (fpga_msg_valid),
    .fpga_msg_full  (fpga_msg_full),
    .rd_req         (rd_req),
    .rd_rsp         (rd_rsp),
    .pc_head        (pc_msg),
    .pc_pending     (pc_msg_pending),
    .app_done       (app_done)
  );

  host_loop_channel u_loop_channel (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .echo_word (pc_msg),
    .echo_push (pc_take),
    .wr_open   (wr_req.open),
    .loop_req  (loop_req),
    .loop_rsp  (loop_rsp)
  );

  // LED 0 pending, 1 read open, 2 write open, 3 application done
  assign status_led = {app_done, wr_req.open, rd_req.open, pc_msg_pending};

endmodule

// ==== verification/tb_host_tasks.svh ====
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// LCG step with the classic C library constants
function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

function automatic logic chance(input int pct);
  logic [31:0] r;
  r = next_rand();
  return ((r >> 8) % 100) < pct;
endfunction

function automatic fpga_msg_t rand_msg();
  fpga_msg_t m;
  m[31:0]  = next_rand();
  m[63:32] = next_rand();
  return m;
endfunction

task automatic expect_val(input string what, input logic [63:0] got, input logic [63:0] exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
  end
endtask

// Compare DUT outputs with the model after an edge
task automatic compare_outputs();
  logic rd_eof;
  rd_eof = ((pc_q.size() > 0) && (pc_q[0] == eof_marker) && (msg_q.size() == 0)) || app_done;
  expect_val("pc_msg_pending", 64'(pc_msg_pending), 64'(pc_q.size() > 0));
  if (pc_q.size() > 0) begin
    expect_val("pc_msg", 64'(pc_msg), 64'(pc_q[0]));
  end
  expect_val("wr_full", 64'(wr_full), 64'(pc_q.size() == pc_fifo_depth));
  expect_val("loop_rsp.empty", 64'(loop_rsp.empty), 64'(loop_q.size() == 0));
  if (loop_q.size() > 0) begin
    expect_val("loop_rsp.data", 64'(loop_rsp.data), 64'(loop_q[0]));
  end
  expect_val("loop_rsp.eof", 64'(loop_rsp.eof),
             64'(!wr_req.open && (loop_q.size() == 0)));
  expect_val("rd_rsp.empty", 64'(rd_rsp.empty), 64'(msg_q.size() == 0));
  if (msg_q.size() > 0) begin
    expect_val("rd_rsp.data", 64'(rd_rsp.data),
               64'(hi_half ? msg_q[0][63:32] : msg_q[0][31:0]));
  end
  expect_val("rd_rsp.eof", 64'(rd_rsp.eof), 64'(rd_eof));
  expect_val("fpga_msg_full", 64'(fpga_msg_full),
             64'(rd_req.open && (msg_q.size() == fpga_fifo_depth)));
  expect_val("status_led", 64'(status_led),
             64'({app_done, wr_req.open, rd_req.open, pc_q.size() > 0}));
endtask

// Apply the effect of the next rising edge to the model
task automatic model_edge();
  logic take;
  logic echo_ok;
  logic push_ok;
  logic word_read;
  logic msg_ok;
  host_word_t head;
  take      = pc_msg_ack && (pc_q.size() > 0);
  head      = (pc_q.size() > 0) ? pc_q[0] : '0;
  push_ok   = wr_req.wren && (pc_q.size() < pc_fifo_depth);
  echo_ok   = take && (loop_q.size() < pc_fifo_depth);
  word_read = rd_req.rden && (msg_q.size() > 0);
  msg_ok    = fpga_msg_valid && rd_req.open && (msg_q.size() < fpga_fifo_depth);
  msg_taken = fpga_msg_valid && (!rd_req.open || msg_ok);
  if (loop_req.rden && (loop_q.size() > 0)) begin
    void'(loop_q.pop_front());
  end
  if (echo_ok) loop_q.push_back(head);
  if (take) void'(pc_q.pop_front());
  if (push_ok) pc_q.push_back(wr_req.data);
  if (word_read && hi_half) void'(msg_q.pop_front());
  if (word_read) hi_half = !hi_half;
  if (msg_ok) msg_q.push_back(fpga_msg);
endtask

// Outputs are settled at the falling edge
task automatic sample_outputs();
  @(negedge bus_clk);
  compare_outputs();
endtask

task automatic advance_edge();
  model_edge();
  @(posedge bus_clk);
endtask

// Inputs are already driven for the coming edge
task automatic finish_cycle();
  sample_outputs();
  advance_edge();
endtask

task automatic report(input string name, input int errs_before);
  test_count++;
  if (err_count == errs_before) begin
    $display("Test %0d %s: ok", test_count, name);
  end else begin
    $display("Test %0d %s: %0d errors", test_count, name, err_count - errs_before);
  end
endtask

task automatic send_host_words();
  int errs;
  errs = err_count;
  wr_req.open <= 1'b1;
  rd_req.open <= 1'b1;
  for (int i = 0; i < pc_cycles; i++) begin
    wr_req.wren   <= (i < pc_cycles - 30) && chance(50);
    wr_req.data   <= next_rand();
    pc_msg_ack    <= chance(40);
    loop_req.rden <= chance(50);
    finish_cycle();
  end
  report("host words to application", errs);
endtask

task automatic read_loopback();
  int errs;
  errs = err_count;
  for (int i = 0; i < loop_cycles; i++) begin
    wr_req.open   <= (i < 80);
    wr_req.wren   <= (i < 80) && chance(40);
    wr_req.data   <= next_rand();
    pc_msg_ack    <= chance(50);
    loop_req.rden <= chance(50);
    finish_cycle();
  end
  wr_req.open <= 1'b1;
  report("loopback echo and eof", errs);
endtask

task automatic send_fpga_msgs();
  int errs;
  errs = err_count;
  wr_req.wren   <= 1'b0;
  pc_msg_ack    <= 1'b1;
  loop_req.rden <= 1'b1;
  for (int i = 0; i < msg_cycles; i++) begin
    // A closed window in the middle drops whatever is offered
    rd_req.open <= !(i >= 40 && i < 60);
    if (msg_taken || !fpga_msg_valid) begin
      fpga_msg       <= rand_msg();
      fpga_msg_valid <= (i < msg_cycles - 30) && chance(60);
    end
    rd_req.rden <= chance(50);
    finish_cycle();
  end
  fpga_msg_valid <= 1'b0;
  report("application messages to host", errs);
endtask

task automatic fill_queues();
  int errs;
  errs = err_count;
  pc_msg_ack  <= 1'b0;
  rd_req.rden <= 1'b0;
  rd_req.open <= 1'b1;
  for (int i = 0; i < 20; i++) begin
    wr_req.wren <= 1'b1;
    wr_req.data <= next_rand();
    finish_cycle();
  end
  wr_req.wren <= 1'b0;
  sample_outputs();
  check_count++;
  if (!wr_full) begin
    err_count++;
    $display("ERR %0t: wr_full low after 20 writes", $time);
  end
  advance_edge();
  pc_msg_ack <= 1'b1;
  for (int i = 0; i < 20; i++) finish_cycle();
  pc_msg_ack <= 1'b0;
  // Message FIFO held full and then drained by host reads
  for (int i = 0; i < 69; i++) begin
    if (msg_taken || !fpga_msg_valid) begin
      fpga_msg       <= rand_msg();
      fpga_msg_valid <= (i < 30);
    end
    rd_req.rden <= (i >= 14);
    sample_outputs();
    if (i == 13) begin
      check_count++;
      if (!fpga_msg_full) begin
        err_count++;
        $display("ERR %0t: fpga_msg_full low with 8 messages queued", $time);
      end
    end
    advance_edge();
  end
  fpga_msg_valid <= 1'b0;
  report("back-pressure", errs);
endtask

task automatic check_eof_and_leds();
  int errs;
  errs = err_count;
  rd_req.rden <= 1'b1;
  wr_req.wren <= 1'b1;
  wr_req.data <= eof_marker;
  finish_cycle();
  wr_req.wren <= 1'b0;
  for (int i = 0; i < 4; i++) finish_cycle();
  sample_outputs();
  check_count++;
  if (!rd_rsp.eof) begin
    err_count++;
    $display("ERR %0t: rd_rsp.eof low with eof_marker at the head", $time);
  end
  advance_edge();
  pc_msg_ack <= 1'b1;
  for (int i = 0; i < 4; i++) finish_cycle();
  pc_msg_ack <= 1'b0;
  app_done   <= 1'b1;
  for (int i = 0; i < 5; i++) finish_cycle();
  app_done <= 1'b0;
  for (int i = 0; i < 5; i++) finish_cycle();
  report("read eof and status lights", errs);
endtask

`endif

// ==== verification/tb_host_bridge.sv ====
module tb_host_bridge;

  import bridge_cfg_pkg::*;
  import host_stream_pkg::*;

  localparam int clk_period = 20;

  // Cycles spent by each test
  // Watchdog limit follows from their sum
  localparam int reset_cycles = 4;
  localparam int pc_cycles    = 130;
  localparam int loop_cycles  = 130;
  localparam int msg_cycles   = 130;
  localparam int bp_cycles    = 110;
  localparam int eof_cycles   = 20;
  localparam int total_cycles =
    reset_cycles + pc_cycles + loop_cycles + msg_cycles + bp_cycles + eof_cycles;

  logic         bus_clk;
  logic         arst_n;
  host_wr_req_t wr_req;
  logic         wr_full;
  host_rd_req_t rd_req;
  host_rd_rsp_t rd_rsp;
  host_rd_req_t loop_req;
  host_rd_rsp_t loop_rsp;
  host_word_t   pc_msg;
  logic         pc_msg_pending;
  logic         pc_msg_ack;
  fpga_msg_t    fpga_msg;
  logic         fpga_msg_valid;
  logic         fpga_msg_full;
  logic         app_done;
  logic [3:0]   status_led;

  // Reference model state
  host_word_t pc_q[$];
  host_word_t loop_q[$];
  fpga_msg_t  msg_q[$];
  logic       hi_half;
  logic       msg_taken;

  logic [31:0] lcg_state;
  int          err_count;
  int          check_count;
  int          test_count;

  host_bridge_top uut (
    .bus_clk        (bus_clk),
    .arst_n         (arst_n),
    .wr_req         (wr_req),
    .wr_full        (wr_full),
    .rd_req         (rd_req),
    .rd_rsp         (rd_rsp),
    .loop_req       (loop_req),
    .loop_rsp       (loop_rsp),
    .pc_msg         (pc_msg),
    .pc_msg_pending (pc_msg_pending),
    .pc_msg_ack     (pc_msg_ack),
    .fpga_msg       (fpga_msg),
    .fpga_msg_valid (fpga_msg_valid),
    .fpga_msg_full  (fpga_msg_full),
    .app_done       (app_done),
    .status_led     (status_led)
  );

  `include "tb_host_tasks.svh"

  // **************************************************************************
  // Clock and watchdog
  // **************************************************************************

  initial begin
    bus_clk = 1'b0;
    forever begin
      #(clk_period / 2) bus_clk = ~bus_clk;
    end
  end

  initial begin
    #(total_cycles * 4 * clk_period);
    $display("Timeout, the tests did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  // **************************************************************************
  // Test sequence
  // **************************************************************************

  initial begin
    lcg_state   = 32'd85154;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    hi_half     = 1'b0;
    msg_taken   = 1'b1;
    arst_n         <= 1'b0;
    wr_req         <= '0;
    rd_req         <= '0;
    loop_req       <= '0;
    pc_msg_ack     <= 1'b0;
    fpga_msg       <= '0;
    fpga_msg_valid <= 1'b0;
    app_done       <= 1'b0;
    repeat (2) @(posedge bus_clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge bus_clk);

    send_host_words();
    read_loopback();
    send_fpga_msgs();
    fill_queues();
    check_eof_and_leds();

    $display("Tests run: %0d, checks: %0d, errors: %0d", test_count, check_count,
             err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+verification
rtl/bridge_cfg_pkg.sv
rtl/host_stream_pkg.sv
rtl/msg_fifo.sv
rtl/host_rd_channel.sv
rtl/host_loop_channel.sv
rtl/host_bridge_top.sv
verification/tb_host_bridge.sv

// ==== Makefile ====
TOP := tb_host_bridge

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -f build.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
